// File: verilog/link_pkg.sv
package link_pkg;

    // ------------------------------------------------------------------------
    // nibble line format
    // ------------------------------------------------------------------------
    localparam int nibble_w         = 4;   // width of qdata.
    localparam int nibbles_per_word = 8;   // nibbles in one frame.
    localparam int phase_w          = 2;   // qclk is clk divided by four.

    typedef logic [nibble_w-1:0] nibble_t;

    typedef logic [$clog2(nibbles_per_word)-1:0] nibble_idx_t;

    typedef logic [phase_w-1:0] phase_t;

    // index of the closing nibble of a frame.
    localparam nibble_idx_t last_nibble = nibble_idx_t'(nibbles_per_word - 1);

    // phase whose closing edge loads and shifts the line data
    localparam phase_t shift_phase = '0;

endpackage

// File: verilog/stream_pkg.sv
package stream_pkg;

    // ------------------------------------------------------------------------
    // word side of the link
    // ------------------------------------------------------------------------
    localparam int word_w = 32;   // host word width.

    typedef logic [word_w-1:0] word_t;

    // outcome of one received frame
    typedef enum logic {
        rx_ok          = 1'b0,   // all nibbles arrived.
        rx_short_frame = 1'b1    // cut off by a new frame mark.
    } rx_status_t;

endpackage

// File: verilog/word_queue.sv
module word_queue
    import stream_pkg::*;
#(
    parameter int queue_depth = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  word_t push_data,
    input  logic  busy,
    output logic  wr,
    output word_t wr_data,
    output logic  full,
    output logic  empty
);

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);

    word_t             mem [queue_depth];
    logic [ptr_w-1:0]  rd_ptr_q;
    logic [ptr_w-1:0]  wr_ptr_q;
    logic [cnt_w-1:0]  count_q;
    logic              wr_q;
    logic              push_ok;

    assign full  = (count_q == cnt_w'(queue_depth));
    assign empty = (count_q == '0);

    // busy rises one cycle late, so wr_q covers that gap.
    assign wr      = !empty && !busy && !wr_q;
    assign wr_data = mem[rd_ptr_q];

    assign push_ok = push && !full;   // dropped when full.

    // ------------------------------------------------------------------------
    // pointers and fill count
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
            wr_q     <= 1'b0;
        end else begin
            wr_q <= wr;
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps at depth.
            end
            if (wr) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push_ok && !wr) begin
                count_q <= count_q + 1'b1;
            end else if (wr && !push_ok) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr_q] <= push_data;
        end
    end

endmodule

// File: verilog/stream_serializer.sv
module stream_serializer
    import link_pkg::*, stream_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    wr,
    input  word_t   wr_data,
    output logic    qclk,
    output logic    frame,
    output nibble_t qdata,
    output logic    busy
);

    word_t       pending_data_q;
    logic        pending_q;
    logic        active_q;
    nibble_idx_t idx_q;
    word_t       shift_q;
    phase_t      phase_q;
    logic        shift_edge;
    logic        start;

    // ------------------------------------------------------------------------
    // quarter rate strobe
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;   // free running.
        end
    end

    assign shift_edge = (phase_q == shift_phase);

    // a write landing on the load edge goes straight to the line
    assign start = shift_edge && !active_q && (pending_q || wr);

    always_ff @(posedge clk) begin
        if (wr) begin
            pending_data_q <= wr_data;
        end
    end

    // ------------------------------------------------------------------------
    // frame control and nibble shifter
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
            active_q  <= 1'b0;
            idx_q     <= '0;
            shift_q   <= '0;
        end else begin
            if (start) begin
                shift_q   <= pending_q ? pending_data_q : wr_data;
                active_q  <= 1'b1;
                idx_q     <= '0;
                pending_q <= pending_q && wr;   // a new word stays pending.
            end else begin
                if (wr) begin
                    pending_q <= 1'b1;
                end
                if (shift_edge && active_q) begin
                    shift_q <= {{nibble_w{1'b0}}, shift_q[word_w-1:nibble_w]};
                    idx_q   <= idx_q + 1'b1;
                    if (idx_q == last_nibble) begin
                        active_q <= 1'b0;   // frame done.
                    end
                end
            end
        end
    end

    assign qdata = shift_q[nibble_w-1:0];
    assign qclk  = phase_q[phase_w-1] && active_q;   // high in phases 2 and 3.
    assign frame = active_q && (idx_q == '0);
    assign busy  = active_q || pending_q;

endmodule

// File: verilog/stream_deserializer.sv
module stream_deserializer
    import link_pkg::*, stream_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx_qclk,
    input  logic       rx_frame,
    input  nibble_t    rx_qdata,
    output logic       rx_valid,
    output word_t      rx_data,
    output rx_status_t rx_status
);

    logic        qclk_q;
    logic        sample_q;
    logic        sample_frame_q;
    nibble_t     sample_nib_q;
    logic        in_frame_q;
    nibble_idx_t idx_q;
    word_t       shift_q;
    word_t       shift_next;

    // ------------------------------------------------------------------------
    // qclk edge detect and line sample
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            qclk_q         <= 1'b0;
            sample_q       <= 1'b0;
            sample_frame_q <= 1'b0;
        end else begin
            qclk_q         <= rx_qclk;
            sample_q       <= rx_qclk && !qclk_q;   // rising qclk.
            sample_frame_q <= rx_frame;
        end
    end

    always_ff @(posedge clk) begin
        sample_nib_q <= rx_qdata;
    end

    // nibbles enter at the top and move down.
    assign shift_next = {sample_nib_q, shift_q[word_w-1:nibble_w]};

    // ------------------------------------------------------------------------
    // frame tracking
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_frame_q <= 1'b0;
            idx_q      <= '0;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (sample_q) begin
                if (sample_frame_q) begin
                    rx_valid   <= in_frame_q;   // previous frame cut short.
                    in_frame_q <= 1'b1;
                    idx_q      <= nibble_idx_t'(1);
                end else if (in_frame_q) begin
                    if (idx_q == last_nibble) begin
                        rx_valid   <= 1'b1;
                        in_frame_q <= 1'b0;
                        idx_q      <= '0;
                    end else begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_q) begin
            if (sample_frame_q) begin
                rx_data   <= shift_q;   // partial word.
                rx_status <= rx_short_frame;
                shift_q   <= {sample_nib_q, {(word_w-nibble_w){1'b0}}};
            end else if (in_frame_q) begin
                shift_q   <= shift_next;
                rx_data   <= shift_next;
                rx_status <= rx_ok;
            end
        end
    end

endmodule

// File: verilog/nibble_link_top.sv
module nibble_link_top
    import link_pkg::*, stream_pkg::*;
#(
    parameter int queue_depth = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  word_t      push_data,
    output logic       full,
    output logic       empty,
    output logic       qclk,
    output logic       frame,
    output nibble_t    qdata,
    input  logic       rx_qclk,
    input  logic       rx_frame,
    input  nibble_t    rx_qdata,
    output logic       rx_valid,
    output word_t      rx_data,
    output rx_status_t rx_status
);

    logic  wr;
    logic  busy;
    word_t wr_data;

    // ------------------------------------------------------------------------
    // transmit side
    // ------------------------------------------------------------------------
    word_queue #(
        .queue_depth (queue_depth)
    ) u_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .busy      (busy),
        .wr        (wr),
        .wr_data   (wr_data),
        .full      (full),
        .empty     (empty)
    );

    stream_serializer u_serializer (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr),
        .wr_data (wr_data),
        .qclk    (qclk),
        .frame   (frame),
        .qdata   (qdata),
        .busy    (busy)
    );

    // receive side, fed only from the top ports.
    stream_deserializer u_deserializer (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_qclk   (rx_qclk),
        .rx_frame  (rx_frame),
        .rx_qdata  (rx_qdata),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_status (rx_status)
    );

endmodule

// File: test/nibble_link_sva.sv
module nibble_link_sva
    import link_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    wr,
    input logic    qclk,
    input logic    frame,
    input nibble_t qdata,
    input logic    busy
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [2:0] since_wr_q;   // cycles since wr, zero when idle.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            since_wr_q <= '0;
        end else if (wr) begin
            since_wr_q <= 3'd1;
        end else if (frame || since_wr_q == 3'd4) begin
            since_wr_q <= '0;
        end else if (since_wr_q != '0) begin
            since_wr_q <= since_wr_q + 3'd1;
        end
    end

    // ------------------------------------------------------------------------
    // line timing
    // ------------------------------------------------------------------------
    qclk_needs_busy: assert property (@(posedge clk) disable iff (!rst_n) qclk |=> busy)
        else $error("busy fell right after qclk was high");

    frame_one_nibble: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(frame) |-> ($past(frame, 4) && !$past(frame, 5)))
        else $error("frame not high for exactly one nibble period");

    qdata_held: assert property (@(posedge clk) disable iff (!rst_n)
        qclk |=> (!qclk || $stable(qdata)))
        else $error("qdata moved while qclk high");

    frame_after_wr: assert property (@(posedge clk) disable iff (!rst_n)
        (since_wr_q == 3'd4) |-> frame)
        else $error("frame did not rise within 4 cycles of wr");

endmodule

bind stream_serializer nibble_link_sva u_line_sva (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr),
    .qclk  (qclk),
    .frame (frame),
    .qdata (qdata),
    .busy  (busy)
);

// File: test/nibble_link_tb.sv
module nibble_link_tb
    import link_pkg::*, stream_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int queue_depth = 4;
    localparam int frame_worst = 40;   // wr delay, 32 line cycles, idle nibble.
    // frames per test: 1, 1, depth + 3, 2, 2
    localparam int cycle_limit = 2 * frame_worst * (queue_depth + 9);
    localparam int rx_wait_max = 3 * frame_worst;

    logic       clk;
    logic       rst_n;
    logic       push;
    word_t      push_data;
    logic       full;
    logic       empty;
    logic       qclk;
    logic       frame;
    nibble_t    qdata;
    logic       rx_qclk;
    logic       rx_frame;
    nibble_t    rx_qdata;
    logic       rx_valid;
    word_t      rx_data;
    rx_status_t rx_status;

    logic       loopback_en;
    logic       drv_qclk;
    logic       drv_frame;
    nibble_t    drv_qdata;

    logic [31:0] lfsr_q;
    int          err_cnt;
    int          check_cnt;
    int          test_cnt;
    int          cycle_cnt;

    nibble_link_top #(
        .queue_depth (queue_depth)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .empty     (empty),
        .qclk      (qclk),
        .frame     (frame),
        .qdata     (qdata),
        .rx_qclk   (rx_qclk),
        .rx_frame  (rx_frame),
        .rx_qdata  (rx_qdata),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_status (rx_status)
    );

    assign rx_qclk  = loopback_en ? qclk  : drv_qclk;
    assign rx_frame = loopback_en ? frame : drv_frame;
    assign rx_qdata = loopback_en ? qdata : drv_qdata;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // random words and compare tasks
    // ------------------------------------------------------------------------
    function automatic logic lfsr_step();
        logic out_bit;
        out_bit = lfsr_q[0];
        lfsr_q  = lfsr_q >> 1;
        if (out_bit) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;   // taps 32 22 2 1.
        end
        return out_bit;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        int    i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[word_w-2:0], lfsr_step()};
        end
        return r;
    endfunction

    task automatic check_word(input string what, input word_t got, input word_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_nibble(input string what, input nibble_t got, input nibble_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input string what, input rx_status_t got,
                                input rx_status_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0d ns: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs0);
        test_cnt++;
        if (err_cnt == errs0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, err_cnt - errs0);
        end
    endtask

    // ------------------------------------------------------------------------
    // host and line drivers, waits
    // ------------------------------------------------------------------------
    task automatic push_word(input word_t w);
        @(posedge clk);
        push      <= 1'b1;
        push_data <= w;
        @(posedge clk);
        push <= 1'b0;
    endtask

    // one nibble period, qclk high in the second half.
    task automatic send_nibble(input nibble_t nib, input logic mark);
        @(posedge clk);
        drv_qclk  <= 1'b0;
        drv_qdata <= nib;
        drv_frame <= mark;
        @(posedge clk);
        @(posedge clk);
        drv_qclk <= 1'b1;
        @(posedge clk);
        @(posedge clk);
    endtask

    task automatic wait_rx(output word_t data, output rx_status_t status, output logic found);
        int n;
        found  = 1'b0;
        data   = '0;
        status = rx_ok;
        for (n = 0; n < rx_wait_max && !found; n++) begin
            @(negedge clk);
            if (rx_valid) begin
                found  = 1'b1;
                data   = rx_data;
                status = rx_status;
            end
        end
        if (!found) begin
            err_cnt++;
            $display("no rx_valid within %0d cycles at %0d ns", rx_wait_max, $time);
        end
    endtask

    task automatic expect_rx(input word_t exp, input rx_status_t exp_status);
        word_t      got;
        rx_status_t status;
        logic       found;
        wait_rx(got, status, found);
        if (found) begin
            check_word("rx_data", got, exp);
            check_status("rx_status", status, exp_status);
        end
    endtask

    task automatic wait_frame(output logic found);
        int n;
        found = 1'b0;
        for (n = 0; n < frame_worst && !found; n++) begin
            @(negedge clk);
            found = frame;
        end
        if (!found) begin
            err_cnt++;
            $display("frame never rose within %0d cycles at %0d ns", frame_worst, $time);
        end
    endtask

    task automatic expect_quiet(input int cycles);
        int n;
        check_cnt++;
        for (n = 0; n < cycles; n++) begin
            @(negedge clk);
            if (rx_valid) begin
                err_cnt++;
                $display("unexpected rx_valid at %0d ns, a dropped word came out", $time);
                break;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------
    task automatic test_single_word();
        word_t w;
        int    errs0;
        errs0 = err_cnt;
        @(negedge clk);
        check_flag("empty", empty, 1'b1);
        check_flag("full", full, 1'b0);
        check_flag("frame", frame, 1'b0);
        check_flag("rx_valid", rx_valid, 1'b0);
        w = rand_bits(word_w);
        push_word(w);
        expect_rx(w, rx_ok);
        report_test("single word", errs0);
    endtask

    task automatic test_nibble_order();
        word_t w;
        logic  qclk_prev;
        int    k;
        int    n;
        int    errs0;
        errs0     = err_cnt;
        w         = 32'h8f1e_2d3c;
        k         = 0;
        qclk_prev = 1'b0;
        push_word(w);
        for (n = 0; n < 2 * frame_worst && k < nibbles_per_word; n++) begin
            @(negedge clk);
            if (qclk && !qclk_prev) begin
                check_nibble("qdata", qdata, w[k*nibble_w +: nibble_w]);   // lsb first.
                check_flag("frame", frame, k == 0);
                k++;
            end
            qclk_prev = qclk;
        end
        if (k < nibbles_per_word) begin
            err_cnt++;
            $display("only %0d of %0d nibbles seen on the line", k, nibbles_per_word);
        end
        expect_rx(w, rx_ok);
        report_test("nibble order", errs0);
    endtask

    task automatic test_queue_fill();
        word_t lead;
        word_t burst [queue_depth+1];
        logic  found;
        int    i;
        int    errs0;
        errs0 = err_cnt;
        lead  = rand_bits(word_w);
        for (i = 0; i <= queue_depth; i++) begin
            burst[i] = rand_bits(word_w);
        end
        push_word(lead);
        wait_frame(found);   // serializer busy, queue holds.
        for (i = 0; i <= queue_depth; i++) begin
            @(posedge clk);
            push      <= 1'b1;
            push_data <= burst[i];
        end
        @(posedge clk);
        push <= 1'b0;
        @(negedge clk);
        check_flag("full", full, 1'b1);
        expect_rx(lead, rx_ok);
        for (i = 0; i < queue_depth; i++) begin
            expect_rx(burst[i], rx_ok);
        end
        @(negedge clk);
        check_flag("empty", empty, 1'b1);
        expect_quiet(2 * frame_worst);
        report_test("queue fill", errs0);
    endtask

    task automatic test_short_frame();
        nibble_t nib;
        word_t   part;
        word_t   w;
        int      i;
        int      errs0;
        errs0 = err_cnt;
        @(posedge clk);
        loopback_en <= 1'b0;
        part = '0;
        for (i = 0; i < 3; i++) begin
            nib = nibble_t'(rand_bits(nibble_w));
            send_nibble(nib, i == 0);
            part[word_w - (3 - i) * nibble_w +: nibble_w] = nib;   // upper bits, first lowest.
        end
        w = rand_bits(word_w);
        send_nibble(w[nibble_w-1:0], 1'b1);   // new mark cuts the frame.
        expect_rx(part, rx_short_frame);
        for (i = 1; i < nibbles_per_word; i++) begin
            send_nibble(w[i*nibble_w +: nibble_w], 1'b0);
        end
        expect_rx(w, rx_ok);
        @(posedge clk);
        drv_qclk    <= 1'b0;
        drv_frame   <= 1'b0;
        loopback_en <= 1'b1;
        report_test("short frame", errs0);
    endtask

    task automatic test_reset_mid_frame();
        word_t w;
        word_t held;
        logic  found;
        int    errs0;
        errs0 = err_cnt;
        w     = rand_bits(word_w);
        held  = rand_bits(word_w);
        push_word(w);
        wait_frame(found);
        push_word(held);   // waits in the queue behind the frame.
        rst_n <= 1'b0;     // first nibble, qclk high.
        @(negedge clk);
        check_flag("busy", uut.u_serializer.busy, 1'b0);
        check_flag("qclk", qclk, 1'b0);
        check_flag("frame", frame, 1'b0);
        check_flag("rx_valid", rx_valid, 1'b0);
        check_flag("empty", empty, 1'b1);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        w = rand_bits(word_w);
        push_word(w);
        expect_rx(w, rx_ok);
        report_test("reset mid frame", errs0);
    endtask

    // ------------------------------------------------------------------------
    // run control
    // ------------------------------------------------------------------------
    initial begin
        err_cnt     = 0;
        check_cnt   = 0;
        test_cnt    = 0;
        lfsr_q      = 32'ha14e_068b;
        rst_n       <= 1'b0;
        push        <= 1'b0;
        push_data   <= '0;
        loopback_en <= 1'b1;
        drv_qclk    <= 1'b0;
        drv_frame   <= 1'b0;
        drv_qdata   <= '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_single_word();
        test_nibble_order();
        test_queue_fill();
        test_short_frame();
        test_reset_mid_frame();
        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout, run stopped after %0d cycles", cycle_limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: sim.f
verilog/link_pkg.sv
verilog/stream_pkg.sv
verilog/word_queue.sv
verilog/stream_serializer.sv
verilog/stream_deserializer.sv
verilog/nibble_link_top.sv
test/nibble_link_sva.sv
test/nibble_link_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the nibble link testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module nibble_link_tb -Mdir obj_dir -f sim.f \
    || { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/Vnibble_link_tb)
echo "$sim_out"

grep -qx "Test OK" <<< "$sim_out" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
